//--- Makefile
TOP := tb_memory_island

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir

# Pass only if the simulation printed the pass line
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

//--- rtl/axi_to_mem_adapter.sv
`timescale 1ns/1ns

module axi_to_mem_adapter import memory_island_pkg::*; #(
    // 1 gives separate write and read ports, 0 one shared port
    parameter bit  ReadWrite = 1'b1,
    parameter type axi_req_t = axi_lite_req_t,
    parameter type axi_rsp_t = axi_lite_rsp_t,
    parameter type mem_req_t = mem_narrow_req_t,
    parameter type mem_rsp_t = mem_narrow_rsp_t
)(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  axi_req_t               axi_req_i,
    output axi_rsp_t               axi_rsp_o,
    output mem_req_t [ReadWrite:0] mem_req_o,
    input  mem_rsp_t [ReadWrite:0] mem_rsp_i
);

    typedef enum logic [1:0] {W_IDLE, W_REQ, W_WAIT, W_RESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT, R_RESP} rd_state_e;

    wr_state_e wr_state_q;
    rd_state_e rd_state_q;

    // Captured transaction payloads
    logic [AddrWidth-1:0]       wr_addr_q;
    logic [NarrowDataWidth-1:0] wr_data_q;
    logic [NarrowStrbWidth-1:0] wr_strb_q;
    logic [AddrWidth-1:0]       rd_addr_q;
    logic [NarrowDataWidth-1:0] rd_data_q;

    logic     aw_take, ar_take;
    logic     wr_pend, rd_pend;
    logic     wr_gnt, wr_rvalid;
    logic     rd_gnt, rd_rvalid;
    logic [NarrowDataWidth-1:0] rd_rdata;
    mem_req_t wr_mem, rd_mem;

    // aw and w only together, and only with no write in flight
    assign aw_take = (wr_state_q == W_IDLE) && axi_req_i.aw_valid && axi_req_i.w_valid;
    assign ar_take = (rd_state_q == R_IDLE) && axi_req_i.ar_valid;
    assign wr_pend = (wr_state_q == W_REQ);
    assign rd_pend = (rd_state_q == R_REQ);

    // --------------------
    // Write machine
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_state_q <= W_IDLE;
        end else begin
            case (wr_state_q)
                W_IDLE:  if (aw_take) wr_state_q <= W_REQ;
                W_REQ:   if (wr_gnt) wr_state_q <= W_WAIT;
                // Write ack comes back as rvalid
                W_WAIT:  if (wr_rvalid) wr_state_q <= W_RESP;
                W_RESP:  if (axi_req_i.b_ready) wr_state_q <= W_IDLE;
                default: wr_state_q <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_take) begin
            wr_addr_q <= axi_req_i.aw_addr;
            wr_data_q <= axi_req_i.w_data;
            wr_strb_q <= axi_req_i.w_strb;
        end
    end

    // --------------------
    // Read machine
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_state_q <= R_IDLE;
        end else begin
            case (rd_state_q)
                R_IDLE:  if (ar_take) rd_state_q <= R_REQ;
                R_REQ:   if (rd_gnt) rd_state_q <= R_WAIT;
                R_WAIT:  if (rd_rvalid) rd_state_q <= R_RESP;
                R_RESP:  if (axi_req_i.r_ready) rd_state_q <= R_IDLE;
                default: rd_state_q <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_take) begin
            rd_addr_q <= axi_req_i.ar_addr;
        end
        // Held stable through R_RESP
        if (rd_state_q == R_WAIT && rd_rvalid) begin
            rd_data_q <= rd_rdata;
        end
    end

    // Memory requests of both machines
    always_comb begin
        wr_mem       = '0;
        wr_mem.req   = wr_pend;
        wr_mem.we    = 1'b1;
        wr_mem.addr  = wr_addr_q;
        wr_mem.wdata = wr_data_q;
        wr_mem.be    = wr_strb_q;
        rd_mem       = '0;
        rd_mem.req   = rd_pend;
        rd_mem.addr  = rd_addr_q;
        rd_mem.be    = '1;
    end

    // --------------------
    // Port mapping
    // --------------------
    if (ReadWrite) begin : g_split
        // Port 0 writes, port 1 reads
        assign mem_req_o[0] = wr_mem;
        assign mem_req_o[1] = rd_mem;
        assign wr_gnt       = mem_rsp_i[0].gnt;
        assign wr_rvalid    = mem_rsp_i[0].rvalid;
        assign rd_gnt       = mem_rsp_i[1].gnt;
        assign rd_rvalid    = mem_rsp_i[1].rvalid;
        assign rd_rdata     = mem_rsp_i[1].rdata;
    end else begin : g_shared
        // Owner keeps the port from request until its rvalid
        logic busy_q, own_rd_q, prio_rd_q;
        logic pick_rd, sel_rd;

        assign pick_rd      = rd_pend && (!wr_pend || prio_rd_q);
        assign sel_rd       = busy_q ? own_rd_q : pick_rd;
        assign mem_req_o[0] = sel_rd ? rd_mem : wr_mem;
        assign wr_gnt       = !sel_rd && mem_rsp_i[0].gnt;
        assign wr_rvalid    = !sel_rd && mem_rsp_i[0].rvalid;
        assign rd_gnt       = sel_rd && mem_rsp_i[0].gnt;
        assign rd_rvalid    = sel_rd && mem_rsp_i[0].rvalid;
        assign rd_rdata     = mem_rsp_i[0].rdata;

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                busy_q    <= 1'b0;
                own_rd_q  <= 1'b0;
                prio_rd_q <= 1'b0;
            end else if (!busy_q && (wr_pend || rd_pend)) begin
                busy_q    <= 1'b1;
                own_rd_q  <= pick_rd;
                // Other kind wins the next contest
                prio_rd_q <= !pick_rd;
            end else if (busy_q && mem_rsp_i[0].rvalid) begin
                busy_q <= 1'b0;
            end
        end
    end

    // AXI responses, always OKAY
    always_comb begin
        axi_rsp_o          = '0;
        axi_rsp_o.aw_ready = aw_take;
        axi_rsp_o.w_ready  = aw_take;
        axi_rsp_o.b_valid  = (wr_state_q == W_RESP);
        axi_rsp_o.b_resp   = AxiRespOkay;
        axi_rsp_o.ar_ready = ar_take;
        axi_rsp_o.r_valid  = (rd_state_q == R_RESP);
        axi_rsp_o.r_data   = rd_data_q;
        axi_rsp_o.r_resp   = AxiRespOkay;
    end

endmodule

//--- rtl/mem_multicut.sv
`timescale 1ns/1ns

module mem_multicut #(
    parameter int unsigned NumCutsReq = 1,
    parameter int unsigned NumCutsRsp = 1,
    parameter type         mem_req_t  = logic,
    parameter type         mem_rsp_t  = logic
)(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  mem_req_t req_i,
    output mem_req_t req_o,
    input  mem_rsp_t rsp_i,
    output mem_rsp_t rsp_o
);

    // Index 0 is the upstream side, index N the downstream side
    logic     req_v   [NumCutsReq+1];
    logic     req_rdy [NumCutsReq+1];
    mem_req_t req_d   [NumCutsReq+1];
    logic     rsp_v   [NumCutsRsp+1];
    mem_rsp_t rsp_d   [NumCutsRsp+1];

    // --------------------
    // Request cuts
    // --------------------
    assign req_v[0]            = req_i.req;
    assign req_d[0]            = req_i;
    // Last stage moves on with the downstream grant
    assign req_rdy[NumCutsReq] = rsp_i.gnt;

    for (genvar i = 0; i < NumCutsReq; i++) begin : g_req_cut
        logic     stage_v_q;
        mem_req_t stage_d_q;

        // Load when empty or when the content leaves
        assign req_rdy[i] = !stage_v_q || req_rdy[i+1];

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                stage_v_q <= 1'b0;
            end else if (req_rdy[i]) begin
                stage_v_q <= req_v[i];
            end
        end

        always_ff @(posedge clk_i) begin
            if (req_rdy[i]) begin
                stage_d_q <= req_d[i];
            end
        end

        assign req_v[i+1] = stage_v_q;
        assign req_d[i+1] = stage_d_q;
    end

    // Stored req bit may be stale, occupancy is what counts
    always_comb begin
        req_o     = req_d[NumCutsReq];
        req_o.req = req_v[NumCutsReq];
    end

    // --------------------
    // Response cuts
    // --------------------
    assign rsp_v[0] = rsp_i.rvalid;
    assign rsp_d[0] = rsp_i;

    // Plain shift chain, rvalid is never back-pressured
    for (genvar i = 0; i < NumCutsRsp; i++) begin : g_rsp_cut
        logic     stage_v_q;
        mem_rsp_t stage_d_q;

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                stage_v_q <= 1'b0;
            end else begin
                stage_v_q <= rsp_v[i];
            end
        end

        always_ff @(posedge clk_i) begin
            stage_d_q <= rsp_d[i];
        end

        assign rsp_v[i+1] = stage_v_q;
        assign rsp_d[i+1] = stage_d_q;
    end

    // Upstream grant is the first stage load
    always_comb begin
        rsp_o        = rsp_d[NumCutsRsp];
        rsp_o.gnt    = req_v[0] && req_rdy[0];
        rsp_o.rvalid = rsp_v[NumCutsRsp];
    end

endmodule

//--- rtl/memory_island_core.sv
`timescale 1ns/1ns

module memory_island_core import memory_island_pkg::*; #(
    parameter int unsigned NumBanks     = 4,
    parameter int unsigned WordsPerBank = 256,
    parameter int unsigned NumNarrow    = 3
)(
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  mem_narrow_req_t [NumNarrow-1:0] mem_narrow_req_i,
    output mem_narrow_rsp_t [NumNarrow-1:0] mem_narrow_rsp_o,
    input  mem_wide_req_t                   mem_wide_req_i,
    output mem_wide_rsp_t                   mem_wide_rsp_o
);

    // Wide requester sits after the narrow ones
    localparam int unsigned NumReq       = NumNarrow + 1;
    localparam int unsigned PtrWidth     = $clog2(NumReq);
    localparam int unsigned BankSelWidth = $clog2(NumBanks);
    localparam int unsigned RowWidth     = (WordsPerBank > 1) ? $clog2(WordsPerBank) : 1;
    localparam int unsigned NumPairs     = NumBanks / 2;

    typedef logic [BankSelWidth-1:0] bank_sel_t;
    typedef logic [RowWidth-1:0]     row_t;

    // Decoded addresses
    bank_sel_t narrow_bank [NumNarrow];
    row_t      narrow_row  [NumNarrow];
    bank_sel_t wide_lo, wide_hi;
    row_t      wide_row;

    // Per-bank access of this cycle
    logic [NumBanks-1:0]        bank_taken;
    logic                       bank_we    [NumBanks];
    row_t                       bank_row   [NumBanks];
    logic [NarrowDataWidth-1:0] bank_wdata [NumBanks];
    logic [NarrowStrbWidth-1:0] bank_be    [NumBanks];

    logic [PtrWidth-1:0]        rr_q;
    logic [NumReq-1:0]          gnt, rvalid_q;
    logic [NarrowDataWidth-1:0] bank_mem     [NumBanks][WordsPerBank];
    logic [NarrowDataWidth-1:0] bank_rdata_q [NumBanks];
    bank_sel_t                  narrow_bank_q [NumNarrow];
    bank_sel_t                  wide_lo_q, wide_hi_q;

    // --------------------
    // Address decode
    // --------------------
    // Word-interleaved, row from the bits above the bank index
    always_comb begin
        for (int n = 0; n < NumNarrow; n++) begin
            narrow_bank[n] = bank_sel_t'(mem_narrow_req_i[n].addr[AddrWidth-1:2] % NumBanks);
            narrow_row[n]  = row_t'((mem_narrow_req_i[n].addr[AddrWidth-1:2] / NumBanks)
                                    % WordsPerBank);
        end
        // A wide word maps to the even bank and its neighbour
        wide_lo  = bank_sel_t'(2 * (mem_wide_req_i.addr[AddrWidth-1:3] % NumPairs));
        wide_hi  = wide_lo | bank_sel_t'(1);
        wide_row = row_t'((mem_wide_req_i.addr[AddrWidth-1:3] / NumPairs) % WordsPerBank);
    end

    // --------------------
    // Arbitration
    // --------------------
    // Walk from the pointer, grant whoever finds its banks free
    always_comb begin
        int unsigned idx;
        gnt        = '0;
        bank_taken = '0;
        for (int b = 0; b < NumBanks; b++) begin
            bank_we[b]    = 1'b0;
            bank_row[b]   = '0;
            bank_wdata[b] = '0;
            bank_be[b]    = '0;
        end
        for (int k = 0; k < NumReq; k++) begin
            idx = (rr_q + k) % NumReq;
            if (idx < NumNarrow) begin
                if (mem_narrow_req_i[idx].req && !bank_taken[narrow_bank[idx]]) begin
                    gnt[idx]                        = 1'b1;
                    bank_taken[narrow_bank[idx]]    = 1'b1;
                    bank_we[narrow_bank[idx]]       = mem_narrow_req_i[idx].we;
                    bank_row[narrow_bank[idx]]      = narrow_row[idx];
                    bank_wdata[narrow_bank[idx]]    = mem_narrow_req_i[idx].wdata;
                    bank_be[narrow_bank[idx]]       = mem_narrow_req_i[idx].be;
                end
            end else if (mem_wide_req_i.req && !bank_taken[wide_lo] && !bank_taken[wide_hi]) begin
                gnt[NumNarrow]      = 1'b1;
                bank_taken[wide_lo] = 1'b1;
                bank_taken[wide_hi] = 1'b1;
                bank_we[wide_lo]    = mem_wide_req_i.we;
                bank_we[wide_hi]    = mem_wide_req_i.we;
                bank_row[wide_lo]   = wide_row;
                bank_row[wide_hi]   = wide_row;
                // Low half to the even bank
                bank_wdata[wide_lo] = mem_wide_req_i.wdata[NarrowDataWidth-1:0];
                bank_wdata[wide_hi] = mem_wide_req_i.wdata[WideDataWidth-1:NarrowDataWidth];
                bank_be[wide_lo]    = mem_wide_req_i.be[NarrowStrbWidth-1:0];
                bank_be[wide_hi]    = mem_wide_req_i.be[WideStrbWidth-1:NarrowStrbWidth];
            end
        end
    end

    // Pointer steps every cycle, rvalid one beat after the grant
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr_q     <= '0;
            rvalid_q <= '0;
        end else begin
            rr_q     <= (rr_q == PtrWidth'(NumReq - 1)) ? '0 : rr_q + 1'b1;
            rvalid_q <= gnt;
        end
    end

    // --------------------
    // Bank storage
    // --------------------
    // Read before write, byte-enabled write
    always_ff @(posedge clk_i) begin
        for (int b = 0; b < NumBanks; b++) begin
            if (bank_taken[b]) begin
                bank_rdata_q[b] <= bank_mem[b][bank_row[b]];
                for (int j = 0; j < NarrowStrbWidth; j++) begin
                    if (bank_we[b] && bank_be[b][j]) begin
                        bank_mem[b][bank_row[b]][8*j +: 8] <= bank_wdata[b][8*j +: 8];
                    end
                end
            end
        end
    end

    // Remember which banks each requester read from
    always_ff @(posedge clk_i) begin
        narrow_bank_q <= narrow_bank;
        wide_lo_q     <= wide_lo;
        wide_hi_q     <= wide_hi;
    end

    // --------------------
    // Responses
    // --------------------
    always_comb begin
        for (int n = 0; n < NumNarrow; n++) begin
            mem_narrow_rsp_o[n].gnt    = gnt[n];
            mem_narrow_rsp_o[n].rvalid = rvalid_q[n];
            mem_narrow_rsp_o[n].rdata  = bank_rdata_q[narrow_bank_q[n]];
        end
        mem_wide_rsp_o.gnt    = gnt[NumNarrow];
        mem_wide_rsp_o.rvalid = rvalid_q[NumNarrow];
        mem_wide_rsp_o.rdata  = {bank_rdata_q[wide_hi_q], bank_rdata_q[wide_lo_q]};
    end

endmodule

//--- rtl/memory_island_pkg.sv
package memory_island_pkg;

    // --------------------
    // Widths
    // --------------------
    // Byte address, taken modulo the memory size inside the core
    localparam int unsigned AddrWidth       = 32;
    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth   = 64;
    localparam int unsigned NarrowStrbWidth = NarrowDataWidth / 8;
    localparam int unsigned WideStrbWidth   = WideDataWidth / 8;

    // OKAY code, the only response this island returns
    localparam logic [1:0] AxiRespOkay = 2'b00;

    // --------------------
    // Memory protocol
    // --------------------
    // Narrow word request, one bank
    typedef struct packed {
        logic                       req;
        logic                       we;
        logic [AddrWidth-1:0]       addr;
        logic [NarrowDataWidth-1:0] wdata;
        logic [NarrowStrbWidth-1:0] be;
    } mem_narrow_req_t;

    // gnt is combinational, rvalid one beat later
    typedef struct packed {
        logic                       gnt;
        logic                       rvalid;
        logic [NarrowDataWidth-1:0] rdata;
    } mem_narrow_rsp_t;

    // Wide word request, covers an even-aligned bank pair
    typedef struct packed {
        logic                     req;
        logic                     we;
        logic [AddrWidth-1:0]     addr;
        logic [WideDataWidth-1:0] wdata;
        logic [WideStrbWidth-1:0] be;
    } mem_wide_req_t;

    typedef struct packed {
        logic                     gnt;
        logic                     rvalid;
        logic [WideDataWidth-1:0] rdata;
    } mem_wide_rsp_t;

    // --------------------
    // AXI-Lite
    // --------------------
    // Master to slave, single-beat channels only
    typedef struct packed {
        logic                       aw_valid;
        logic [AddrWidth-1:0]       aw_addr;
        logic                       w_valid;
        logic [NarrowDataWidth-1:0] w_data;
        logic [NarrowStrbWidth-1:0] w_strb;
        logic                       b_ready;
        logic                       ar_valid;
        logic [AddrWidth-1:0]       ar_addr;
        logic                       r_ready;
    } axi_lite_req_t;

    // Slave to master
    typedef struct packed {
        logic                       aw_ready;
        logic                       w_ready;
        logic                       b_valid;
        logic [1:0]                 b_resp;
        logic                       ar_ready;
        logic                       r_valid;
        logic [NarrowDataWidth-1:0] r_data;
        logic [1:0]                 r_resp;
    } axi_lite_rsp_t;

endpackage

//--- rtl/memory_island_wrap.sv
`timescale 1ns/1ns

module memory_island_wrap import memory_island_pkg::*; #(
    parameter int unsigned NumBanks     = 4,
    parameter int unsigned WordsPerBank = 256,
    parameter int unsigned NumCutsReq   = 1,
    parameter int unsigned NumCutsRsp   = 1,
    // Split read and write ports behind the AXI adapter
    parameter bit          AxiReadWrite = 1'b1
)(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  axi_lite_req_t   axi_req_i,
    output axi_lite_rsp_t   axi_rsp_o,
    input  mem_narrow_req_t mem_narrow_req_i,
    output mem_narrow_rsp_t mem_narrow_rsp_o,
    input  mem_wide_req_t   mem_wide_req_i,
    output mem_wide_rsp_t   mem_wide_rsp_o
);

    localparam int unsigned NumAxiPorts = 1 + AxiReadWrite;
    // Direct narrow port plus the adapter ports
    localparam int unsigned NumNarrow   = 1 + NumAxiPorts;

    // Adapter side and core side of the entry cuts
    mem_narrow_req_t [NumAxiPorts-1:0] adapter_req, island_req;
    mem_narrow_rsp_t [NumAxiPorts-1:0] adapter_rsp, island_rsp;

    // Aggregated narrow channels, direct port at index 0
    mem_narrow_req_t [NumNarrow-1:0] core_narrow_req;
    mem_narrow_rsp_t [NumNarrow-1:0] core_narrow_rsp;

    assign core_narrow_req  = {island_req, mem_narrow_req_i};
    assign mem_narrow_rsp_o = core_narrow_rsp[0];
    assign island_rsp       = core_narrow_rsp[NumNarrow-1:1];

    // --------------------
    // AXI adapter
    // --------------------
    axi_to_mem_adapter #(
        .ReadWrite (AxiReadWrite),
        .axi_req_t (axi_lite_req_t),
        .axi_rsp_t (axi_lite_rsp_t),
        .mem_req_t (mem_narrow_req_t),
        .mem_rsp_t (mem_narrow_rsp_t)
    ) u_axi_to_mem_adapter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .axi_req_i (axi_req_i),
        .axi_rsp_o (axi_rsp_o),
        .mem_req_o (adapter_req),
        .mem_rsp_i (adapter_rsp)
    );

    // --------------------
    // Entry cuts
    // --------------------
    // One cut chain per adapter port
    for (genvar i = 0; i < NumAxiPorts; i++) begin : g_spill_entry
        mem_multicut #(
            .NumCutsReq (NumCutsReq),
            .NumCutsRsp (NumCutsRsp),
            .mem_req_t  (mem_narrow_req_t),
            .mem_rsp_t  (mem_narrow_rsp_t)
        ) u_spill_entry (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (adapter_req[i]),
            .req_o   (island_req[i]),
            .rsp_i   (island_rsp[i]),
            .rsp_o   (adapter_rsp[i])
        );
    end

    // --------------------
    // Core
    // --------------------
    memory_island_core #(
        .NumBanks     (NumBanks),
        .WordsPerBank (WordsPerBank),
        .NumNarrow    (NumNarrow)
    ) i_memory_island_core (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .mem_narrow_req_i (core_narrow_req),
        .mem_narrow_rsp_o (core_narrow_rsp),
        .mem_wide_req_i   (mem_wide_req_i),
        .mem_wide_rsp_o   (mem_wide_rsp_o)
    );

endmodule

//--- tb/tb_memory_island.sv
`timescale 1ns/1ns

module tb_memory_island import memory_island_pkg::*; ();

    localparam int unsigned ClkPeriod = 8;
    // 4 banks of 256 narrow words, as in the wrapper defaults
    localparam int unsigned MemBytes  = 4 * 256 * NarrowStrbWidth;
    localparam int unsigned FillWords = MemBytes / 8;
    localparam int unsigned NarrowOps = 200;
    localparam int unsigned AxiOps    = 20;
    localparam int unsigned StallOps  = 10;
    localparam int unsigned MixOps    = 150;
    localparam int unsigned MixAxiOps = 30;
    // Stalled AXI ops run twice, counted double
    localparam int unsigned NumOps    = 2 * FillWords + NarrowOps + 3 * AxiOps
                                      + 4 * StallOps + 2 * MixOps + 4 * MixAxiOps;
    // Worst case cycles for one op, arbitration and stalls included
    localparam int unsigned OpBound   = 64;
    localparam int unsigned LimitNs   = (NumOps * OpBound + 64) * ClkPeriod;

    logic            clk;
    logic            rst_n;
    axi_lite_req_t   axi_req;
    axi_lite_rsp_t   axi_rsp;
    mem_narrow_req_t narrow_req;
    mem_narrow_rsp_t narrow_rsp;
    mem_wide_req_t   wide_req;
    mem_wide_rsp_t   wide_rsp;
    integer          seed;

    // Byte-wide reference of the whole island
    logic [7:0] model_mem [MemBytes];

    memory_island_wrap dut_i (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .axi_req_i        (axi_req),
        .axi_rsp_o        (axi_rsp),
        .mem_narrow_req_i (narrow_req),
        .mem_narrow_rsp_o (narrow_rsp),
        .mem_wide_req_i   (wide_req),
        .mem_wide_rsp_o   (wide_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Watchdog sized from the op count
    initial begin
        #(LimitNs);
        $display("Timeout: a request or response never arrived within %0d ns", LimitNs);
        $display("TEST FAIL");
        $fatal(1);
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] rand32();
        return $unsigned($random(seed));
    endfunction

    // Offset in [base, base+span), random alias bits above the memory size
    function automatic logic [31:0] rand_addr(input int unsigned base, input int unsigned span,
                                              input int unsigned align);
        logic [31:0] offs;
        offs = (base + rand32() % span) & ~(align - 1);
        return (rand32() & ~(MemBytes - 1)) | offs;
    endfunction

    // Little endian, byte j of the word at addr + j
    function automatic logic [63:0] model_read(input logic [31:0] addr, input int unsigned n);
        logic [63:0] data;
        data = '0;
        for (int j = 0; j < n; j++) begin
            data[8*j +: 8] = model_mem[(addr + j) % MemBytes];
        end
        return data;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [63:0] data,
                               input logic [7:0] be, input int unsigned n);
        for (int j = 0; j < n; j++) begin
            if (be[j]) model_mem[(addr + j) % MemBytes] = data[8*j +: 8];
        end
    endtask

    // --------------------
    // Direct ports
    // --------------------
    // Outputs sampled 2 ns after the falling edge, well before the rising one
    task automatic narrow_op(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be);
        logic [31:0] expected;
        expected = '0;
        @(negedge clk);
        narrow_req.req   = 1'b1;
        narrow_req.we    = we;
        narrow_req.addr  = addr;
        narrow_req.wdata = wdata;
        narrow_req.be    = be;
        #2;
        while (!narrow_rsp.gnt) begin
            check_equal(narrow_rsp.rvalid, 0, "narrow rvalid without gnt");
            @(negedge clk);
            #2;
        end
        // Granted on the coming rising edge
        if (we) model_write(addr, 64'(wdata), 8'(be), 4);
        else expected = 32'(model_read(addr, 4));
        @(negedge clk);
        narrow_req.req = 1'b0;
        #2;
        check_equal(narrow_rsp.rvalid, 1, "narrow rvalid one cycle after gnt");
        if (!we) check_equal(narrow_rsp.rdata, expected, "narrow rdata");
    endtask

    task automatic wide_op(input logic we, input logic [31:0] addr,
                           input logic [63:0] wdata, input logic [7:0] be);
        logic [63:0] expected;
        expected = '0;
        @(negedge clk);
        wide_req.req   = 1'b1;
        wide_req.we    = we;
        wide_req.addr  = addr;
        wide_req.wdata = wdata;
        wide_req.be    = be;
        #2;
        while (!wide_rsp.gnt) begin
            check_equal(wide_rsp.rvalid, 0, "wide rvalid without gnt");
            @(negedge clk);
            #2;
        end
        if (we) model_write(addr, wdata, be, 8);
        else expected = model_read(addr, 8);
        @(negedge clk);
        wide_req.req = 1'b0;
        #2;
        check_equal(wide_rsp.rvalid, 1, "wide rvalid one cycle after gnt");
        if (!we) check_equal(wide_rsp.rdata, expected, "wide rdata");
    endtask

    // --------------------
    // AXI-Lite master
    // --------------------
    // With stall the same write goes out twice, the second one waiting behind the held B
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input bit stall);
        int unsigned total;
        int unsigned issued;
        int unsigned acked;
        bit          b_seen;
        bit          b_held;
        total  = stall ? 2 : 1;
        issued = 0;
        acked  = 0;
        b_seen = 1'b0;
        b_held = 1'b0;
        @(negedge clk);
        axi_req.aw_valid = 1'b1;
        axi_req.aw_addr  = addr;
        axi_req.w_valid  = 1'b1;
        axi_req.w_data   = data;
        axi_req.w_strb   = strb;
        axi_req.b_ready  = !stall;
        while (acked < total) begin
            #2;
            check_equal(axi_rsp.w_ready, axi_rsp.aw_ready, "w_ready apart from aw_ready");
            if (axi_rsp.aw_ready) begin
                check_equal(issued, acked, "write accepted while one is outstanding");
                issued++;
            end
            if (b_held) check_equal(axi_rsp.b_valid, 1, "b_valid dropped before b_ready");
            if (axi_rsp.b_valid) begin
                check_equal(axi_rsp.b_resp, AxiRespOkay, "b_resp");
                if (!b_seen) model_write(addr, 64'(data), 8'(strb), 4);
                b_seen = 1'b1;
                if (axi_req.b_ready) begin
                    acked++;
                    b_seen = 1'b0;
                end
            end
            b_held = axi_rsp.b_valid && !axi_req.b_ready;
            @(negedge clk);
            if (issued == total) begin
                axi_req.aw_valid = 1'b0;
                axi_req.w_valid  = 1'b0;
            end
            axi_req.b_ready = !stall || (rand32() % 4 == 0);
        end
    endtask

    task automatic axi_read(input logic [31:0] addr, input bit stall);
        int unsigned total;
        int unsigned issued;
        int unsigned acked;
        bit          r_held;
        logic [31:0] held_data;
        total     = stall ? 2 : 1;
        issued    = 0;
        acked     = 0;
        r_held    = 1'b0;
        held_data = '0;
        @(negedge clk);
        axi_req.ar_valid = 1'b1;
        axi_req.ar_addr  = addr;
        axi_req.r_ready  = !stall;
        while (acked < total) begin
            #2;
            if (axi_rsp.ar_ready) begin
                check_equal(issued, acked, "read accepted while one is outstanding");
                issued++;
            end
            if (r_held) begin
                check_equal(axi_rsp.r_valid, 1, "r_valid dropped before r_ready");
                check_equal(axi_rsp.r_data, held_data, "r_data changed while held");
            end
            if (axi_rsp.r_valid) begin
                check_equal(axi_rsp.r_resp, AxiRespOkay, "r_resp");
                if (axi_req.r_ready) begin
                    check_equal(axi_rsp.r_data, model_read(addr, 4), "axi r_data");
                    acked++;
                end
            end
            r_held    = axi_rsp.r_valid && !axi_req.r_ready;
            held_data = axi_rsp.r_data;
            @(negedge clk);
            if (issued == total) axi_req.ar_valid = 1'b0;
            axi_req.r_ready = !stall || (rand32() % 4 == 0);
        end
    endtask

    // Concurrent streams, one address range each, all ranges span every bank
    task automatic narrow_traffic();
        for (int i = 0; i < MixOps; i++) begin
            narrow_op(rand32() % 2, rand_addr(0, 1024, 4), rand32(), 4'(rand32()));
        end
    endtask

    task automatic wide_traffic();
        for (int i = 0; i < MixOps; i++) begin
            wide_op(rand32() % 2, rand_addr(2048, 2048, 8), {rand32(), rand32()},
                    8'(rand32()));
        end
    endtask

    task automatic axi_traffic();
        logic [31:0] addr;
        for (int i = 0; i < MixAxiOps; i++) begin
            addr = rand_addr(1024, 1024, 4);
            if (rand32() % 2 == 1) axi_write(addr, rand32(), 4'(rand32()), rand32() % 2);
            else axi_read(addr, rand32() % 2);
        end
    endtask

    task automatic check_idle_outputs(input string when);
        check_equal(narrow_rsp.gnt, 0, {"narrow gnt ", when});
        check_equal(narrow_rsp.rvalid, 0, {"narrow rvalid ", when});
        check_equal(wide_rsp.gnt, 0, {"wide gnt ", when});
        check_equal(wide_rsp.rvalid, 0, {"wide rvalid ", when});
        check_equal({axi_rsp.aw_ready, axi_rsp.w_ready, axi_rsp.ar_ready}, 0,
                    {"axi ready ", when});
        check_equal({axi_rsp.b_valid, axi_rsp.r_valid}, 0, {"axi valid ", when});
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin
        logic [31:0] addr;
        logic [31:0] axi_addrs [$];
        seed       = 32'h3291572b;
        rst_n      = 1'b0;
        axi_req    = '0;
        narrow_req = '0;
        wide_req   = '0;
        repeat (16) @(negedge clk);
        #2;
        check_idle_outputs("in reset");
        @(negedge clk);
        rst_n = 1'b1;
        #2;
        check_idle_outputs("after reset");

        // Wide fill of the whole memory, then read back
        for (int i = 0; i < FillWords; i++) begin
            wide_op(1'b1, 32'(8 * i), {rand32(), rand32()}, 8'hff);
        end
        for (int i = 0; i < FillWords; i++) begin
            wide_op(1'b0, 32'(8 * i), '0, '0);
        end

        // Narrow port in a small window, so reads hit partial writes
        for (int i = 0; i < NarrowOps; i++) begin
            narrow_op(rand32() % 2, rand_addr(0, 256, 4), rand32(), 4'(rand32()));
        end

        // AXI writes and read back, then reads of direct port data
        for (int i = 0; i < AxiOps; i++) begin
            addr = rand_addr(0, MemBytes, 4);
            axi_addrs.push_back(addr);
            axi_write(addr, rand32(), 4'(rand32()), 1'b0);
        end
        foreach (axi_addrs[i]) axi_read(axi_addrs[i], 1'b0);
        for (int i = 0; i < AxiOps; i++) begin
            axi_read(rand_addr(0, MemBytes, 4), 1'b0);
        end

        // All three ports at once
        fork
            narrow_traffic();
            wide_traffic();
            axi_traffic();
        join

        // Held B and R responses
        for (int i = 0; i < StallOps; i++) begin
            addr = rand_addr(0, MemBytes, 4);
            axi_write(addr, rand32(), 4'(rand32()), 1'b1);
            axi_read(addr, 1'b1);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- vlog.f
rtl/memory_island_pkg.sv
rtl/axi_to_mem_adapter.sv
rtl/mem_multicut.sv
rtl/memory_island_core.sv
rtl/memory_island_wrap.sv
tb/tb_memory_island.sv
